//--- bench/lsu_sva.sv
`timescale 1ns/100ps

module lsu_sva (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          instr_rdy,
    input logic [lsu_pkg::NUM_BANKS-1:0] wr_en,
    input logic                          rd_en,
    input logic                          rd_vld
);

    int fail_count = 0;

    // the opcode picks a single bank
    wr_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(wr_en))
        else begin
            $error("more than one bank write strobe is high");
            fail_count++;
        end

    // writes only happen while an instruction is in flight
    wr_when_busy: assert property (@(posedge clk) disable iff (!arst_n) |wr_en |-> !instr_rdy)
        else begin
            $error("bank write while instr_rdy is high");
            fail_count++;
        end

    rd_vld_after_en: assert property (@(posedge clk) disable iff (!arst_n) rd_en |=> rd_vld)
        else begin
            $error("rd_vld missing one cycle after rd_en");
            fail_count++;
        end

    rd_vld_only_after_en: assert property (@(posedge clk) disable iff (!arst_n)
        !rd_en |=> !rd_vld)
        else begin
            $error("rd_vld high without a read one cycle earlier");
            fail_count++;
        end

endmodule

// store_ctrl strobes and buffer_readout handshake, as wired in the top level
bind lsu_top lsu_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr_rdy (instr_rdy),
    .wr_en     (wr_en),
    .rd_en     (rd_en),
    .rd_vld    (rd_vld)
);

//--- bench/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RAND_STORES = 6;
    // tests 1, 4, 5 and 6 add one store each
    localparam int TOTAL_STORES = 2 * RAND_STORES + 4;
    localparam int MAX_ROWS     = TOTAL_STORES * NUM_ROWS;
    // a stall is always followed by a ready cycle
    localparam int MAX_STALLS   = RAND_STORES * NUM_ROWS;
    localparam int MAX_READS    = TOTAL_STORES * (NUM_ROWS + 1) + BUF_DEPTH + 1;
    localparam int CYCLE_LIMIT  = 2 * MAX_ROWS + MAX_STALLS + MAX_READS + 100;

    logic       clk;
    logic       arst_n;
    logic       instr_vld;
    lsu_op_t    instr_op;
    row_idx_t   start_x;
    row_idx_t   start_y;
    logic [7:0] row_num;
    logic [2:0] len;
    logic [11:0] ld_st_addr;
    mxu_rows_t  mxu_rows;
    logic       mxu_data_rdy;
    logic       rd_en;
    bank_sel_t  rd_bank;
    buf_addr_t  rd_addr;
    logic       instr_rdy;
    logic       rd_vld;
    row_t       rd_data;

    // reference copy of both buffers
    row_t model_mem [NUM_BANKS][BUF_DEPTH];
    bit   model_known [NUM_BANKS][BUF_DEPTH];

    logic [31:0] lfsr_state = 32'ha232;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    lsu_top UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_vld    (instr_vld),
        .instr_op     (instr_op),
        .start_x      (start_x),
        .start_y      (start_y),
        .row_num      (row_num),
        .len          (len),
        .ld_st_addr   (ld_st_addr),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .rd_en        (rd_en),
        .rd_bank      (rd_bank),
        .rd_addr      (rd_addr),
        .instr_rdy    (instr_rdy),
        .rd_vld       (rd_vld),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[31]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    // row shifted right by whole bytes with bits above the window cleared
    function automatic row_t expected_row(input row_t src, input int sx, input logic [2:0] ln);
        int   width;
        row_t res;
        width = 8 << ((ln > 3'd4) ? 4 : ln);
        res = src >> (sx * 8);
        for (int b = 0; b < ROW_BITS; b++) begin
            if (b >= width) begin
                res[b] = 1'b0;
            end
        end
        return res;
    endfunction

    function automatic int total_errors();
        return error_count + UUT.u_sva.fail_count;
    endfunction

    task automatic load_rows();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int w = 0; w < ROW_BITS / 32; w++) begin
                mxu_rows[r][w*32 +: 32] = take_bits(32);
            end
        end
    endtask

    task automatic check_word(input int bank, input int addr, input row_t got);
        check_count++;
        assert (got === model_mem[bank][addr]) else begin
            error_count++;
            $display("[ERROR] %0t ns: bank %0d word %0d read %h, expected %h",
                     $time, bank, addr, got, model_mem[bank][addr]);
        end
    endtask

    // back-to-back reads with each result checked one cycle after its request
    task automatic scan_bank(input int bank, input int first, input int cnt);
        int addr;
        for (int i = 0; i <= cnt; i++) begin
            if (i > 0) begin
                addr = (first + i - 1) % BUF_DEPTH;
                check_count++;
                assert (rd_vld) else begin
                    error_count++;
                    $display("[ERROR] %0t ns: read of bank %0d word %0d got no rd_vld",
                             $time, bank, addr);
                end
                if (model_known[bank][addr]) begin
                    check_word(bank, addr, rd_data);
                end
            end
            rd_en   = (i < cnt);
            rd_bank = bank_sel_t'(bank);
            rd_addr = buf_addr_t'(first + i);
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic run_store(input lsu_op_t op, input row_idx_t sx, input row_idx_t sy,
                             input logic [7:0] n, input logic [2:0] ln,
                             input logic [11:0] addr, input bit stall, input bit intrude);
        int ready_edges;
        int cycles;
        int word;
        bit was_stall;
        load_rows();
        check_count++;
        assert (instr_rdy) else begin
            error_count++;
            $display("[ERROR] %0t ns: instr_rdy low before a new instruction", $time);
        end
        instr_vld  = 1'b1;
        instr_op   = op;
        start_x    = sx;
        start_y    = sy;
        row_num    = n;
        len        = ln;
        ld_st_addr = addr;
        @(posedge clk);
        #DRIVE_DLY;
        ready_edges = 0;
        cycles      = 0;
        was_stall   = 1'b0;
        // second instruction while busy is to be ignored
        instr_vld = intrude;
        if (intrude) begin
            start_y    = sy + 4'd1;
            start_x    = '0;
            len        = 3'd4;
            ld_st_addr = addr + 12'h100;
        end
        do begin
            mxu_data_rdy = (stall && !was_stall) ? (take_bits(1) != 0) : 1'b1;
            was_stall = !mxu_data_rdy;
            @(posedge clk);
            cycles++;
            if (mxu_data_rdy) begin
                ready_edges++;
            end
            #DRIVE_DLY;
            instr_vld = 1'b0;
        end while (!instr_rdy);
        mxu_data_rdy = 1'b0;
        check_count++;
        assert (ready_edges == int'(n)) else begin
            error_count++;
            $display("[ERROR] %0t ns: store ended after %0d ready cycles, expected %0d",
                     $time, ready_edges, n);
        end
        if (!stall) begin
            check_count++;
            assert (cycles == int'(n)) else begin
                error_count++;
                $display("[ERROR] %0t ns: store took %0d cycles, expected %0d",
                         $time, cycles, n);
            end
        end
        for (int k = 0; k < int'(n); k++) begin
            word = (int'(addr[11:4]) + k) % BUF_DEPTH;
            model_mem[int'(op)][word] = expected_row(mxu_rows[int'(sy) + k], sx, ln);
            model_known[int'(op)][word] = 1'b1;
        end
        scan_bank(int'(op), int'(addr[11:4]), int'(n));
    endtask

    // random window and row run that stays inside the result array
    task automatic rand_store(input lsu_op_t op, input bit stall);
        logic [2:0] ln;
        int width;
        int sx;
        int sy;
        int n;
        ln    = 3'(take_bits(3));
        width = 8 << ((ln > 3'd4) ? 4 : ln);
        sx    = int'(take_bits(4)) % ((ROW_BITS - width) / 8 + 1);
        sy    = int'(take_bits(4));
        n     = 1 + int'(take_bits(4)) % (NUM_ROWS - sy);
        run_store(op, row_idx_t'(sx), row_idx_t'(sy), 8'(n), ln, 12'(take_bits(12)),
                  stall, 1'b0);
    endtask

    // read of bank 0 word 0 on the same edge as a one-row write to it
    task automatic collide_test();
        load_rows();
        instr_vld    = 1'b1;
        instr_op     = op_st_iram;
        start_x      = '0;
        start_y      = '0;
        row_num      = 8'd1;
        len          = 3'd4;
        ld_st_addr   = 12'h000;
        mxu_data_rdy = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        instr_vld = 1'b0;
        rd_en     = 1'b1;
        rd_bank   = 1'b0;
        rd_addr   = 8'd0;
        @(posedge clk);
        #DRIVE_DLY;
        check_count++;
        assert (rd_vld) else begin
            error_count++;
            $display("[ERROR] %0t ns: colliding read got no rd_vld", $time);
        end
        check_word(0, 0, rd_data);
        model_mem[0][0] = expected_row(mxu_rows[0], 0, 3'd4);
        @(posedge clk);
        #DRIVE_DLY;
        check_word(0, 0, rd_data);
        rd_en        = 1'b0;
        mxu_data_rdy = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            $display("test %0d, %s: ok", num, name);
        end else begin
            $display("test %0d, %s: %0d errors", num, name, errs);
        end
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the LSU stopped responding", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int errs_before;
        arst_n       = 1'b0;
        instr_vld    = 1'b0;
        instr_op     = op_st_iram;
        start_x      = '0;
        start_y      = '0;
        row_num      = '0;
        len          = '0;
        ld_st_addr   = '0;
        mxu_rows     = '0;
        mxu_data_rdy = 1'b0;
        rd_en        = 1'b0;
        rd_bank      = '0;
        rd_addr      = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        errs_before = total_errors();
        check_count++;
        assert (instr_rdy && !rd_vld) else begin
            error_count++;
            $display("[ERROR] %0t ns: instr_rdy low or rd_vld high after reset", $time);
        end
        run_store(op_st_iram, 4'd0, 4'd0, 8'd16, 3'd4, 12'h000, 1'b0, 1'b0);
        report_test(1, "full-width store to input buffer", errs_before);

        errs_before = total_errors();
        repeat (RAND_STORES) rand_store(op_st_wram, 1'b0);
        report_test(2, "random windows to weight buffer", errs_before);

        errs_before = total_errors();
        repeat (RAND_STORES) rand_store(op_st_iram, 1'b1);
        report_test(3, "stores with matrix unit stalls", errs_before);

        errs_before = total_errors();
        run_store(op_st_wram, 4'd2, 4'd3, 8'd8, 3'd2, 12'h400, 1'b0, 1'b1);
        report_test(4, "instruction ignored while busy", errs_before);

        errs_before = total_errors();
        run_store(op_st_wram, 4'd0, 4'd0, 8'd16, 3'd3, 12'h000, 1'b0, 1'b0);
        scan_bank(0, 0, BUF_DEPTH);
        report_test(5, "other bank left unchanged", errs_before);

        errs_before = total_errors();
        collide_test();
        report_test(6, "read during write of same word", errs_before);

        $display("checks: %0d, errors: %0d", check_count, total_errors());
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- rtl/buffer_bank.sv
`timescale 1ns/100ps

module buffer_bank (
    input  logic               clk,
    input  logic               wr_en,
    input  lsu_pkg::buf_addr_t wr_addr,
    input  lsu_pkg::buf_addr_t rd_addr,
    input  lsu_pkg::row_t      wr_data,
    output lsu_pkg::row_t      rd_data
);
    import lsu_pkg::*;

    row_t mem [BUF_DEPTH];

    // synchronous write and read on the same edge
    // a colliding read sees the word before this write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/buffer_readout.sv
`timescale 1ns/100ps

module buffer_readout (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rd_en,
    input  lsu_pkg::bank_sel_t rd_bank,
    input  lsu_pkg::row_t      bank_data [lsu_pkg::NUM_BANKS],
    output logic               rd_vld,
    output lsu_pkg::row_t      rd_data
);
    import lsu_pkg::*;

    bank_sel_t bank_q;

    // valid lines up with the bank's registered read data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            bank_q <= rd_bank;
        end
    end

    // all banks read every cycle, only the requested one is returned
    assign rd_data = bank_data[bank_q];

endmodule

//--- rtl/lsu_pkg.sv
package lsu_pkg;

    // result array and buffer geometry
    localparam int NUM_ROWS  = 16;
    localparam int ROW_BITS  = 128;
    localparam int BUF_DEPTH = 256;
    localparam int NUM_BANKS = 2;

    localparam int ADDR_BITS = $clog2(BUF_DEPTH);
    localparam int ROW_IDX_BITS = $clog2(NUM_ROWS);
    localparam int BANK_BITS = $clog2(NUM_BANKS);

    typedef logic [ROW_BITS-1:0] row_t;
    typedef row_t [NUM_ROWS-1:0] mxu_rows_t;
    typedef logic [ADDR_BITS-1:0] buf_addr_t;
    typedef logic [ROW_IDX_BITS-1:0] row_idx_t;
    typedef logic [BANK_BITS-1:0] bank_sel_t;

    // opcode value doubles as the target bank index
    typedef enum logic [BANK_BITS-1:0] {
        op_st_iram = 1'b0,
        op_st_wram = 1'b1
    } lsu_op_t;

    typedef enum logic {
        st_idle,
        st_store
    } store_state_t;

    // len code to window width in bits, 8 << len, saturating at a full row
    function automatic logic [7:0] window_bits(input logic [2:0] len);
        case (len)
            3'd0: return 8'd8;
            3'd1: return 8'd16;
            3'd2: return 8'd32;
            3'd3: return 8'd64;
            default: return 8'd128;
        endcase
    endfunction

endpackage

//--- rtl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_vld,
    input  lsu_pkg::lsu_op_t   instr_op,
    input  lsu_pkg::row_idx_t  start_x,
    input  lsu_pkg::row_idx_t  start_y,
    input  logic [7:0]         row_num,
    input  logic [2:0]         len,
    input  logic [11:0]        ld_st_addr,
    input  lsu_pkg::mxu_rows_t mxu_rows,
    input  logic               mxu_data_rdy,
    input  logic               rd_en,
    input  lsu_pkg::bank_sel_t rd_bank,
    input  lsu_pkg::buf_addr_t rd_addr,
    output logic               instr_rdy,
    output logic               rd_vld,
    output lsu_pkg::row_t      rd_data
);
    import lsu_pkg::*;

    // write side, shared by all banks except for the strobe
    row_idx_t             row_sel;
    logic [6:0]           win_shift;
    logic [7:0]           win_len;
    logic [NUM_BANKS-1:0] wr_en;
    buf_addr_t            wr_addr;
    row_t                 wr_data;

    // read data from each bank
    row_t bank_data [NUM_BANKS];

    store_ctrl u_store_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_vld    (instr_vld),
        .instr_op     (instr_op),
        .start_x      (start_x),
        .start_y      (start_y),
        .row_num      (row_num),
        .len          (len),
        .ld_st_addr   (ld_st_addr),
        .mxu_data_rdy (mxu_data_rdy),
        .instr_rdy    (instr_rdy),
        .row_sel      (row_sel),
        .win_shift    (win_shift),
        .win_len      (win_len),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr)
    );

    row_extract u_row_extract (
        .mxu_rows  (mxu_rows),
        .row_sel   (row_sel),
        .win_shift (win_shift),
        .win_len   (win_len),
        .wr_data   (wr_data)
    );

    // bank 0 is the input buffer, bank 1 the weight buffer
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        buffer_bank u_bank (
            .clk     (clk),
            .wr_en   (wr_en[i]),
            .wr_addr (wr_addr),
            .rd_addr (rd_addr),
            .wr_data (wr_data),
            .rd_data (bank_data[i])
        );
    end

    buffer_readout u_buffer_readout (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .bank_data (bank_data),
        .rd_vld    (rd_vld),
        .rd_data   (rd_data)
    );

endmodule

//--- rtl/row_extract.sv
`timescale 1ns/100ps

module row_extract (
    input  lsu_pkg::mxu_rows_t mxu_rows,
    input  lsu_pkg::row_idx_t  row_sel,
    input  logic [6:0]         win_shift,
    input  logic [7:0]         win_len,
    output lsu_pkg::row_t      wr_data
);
    import lsu_pkg::*;

    row_t row_raw;
    row_t row_shifted;
    row_t win_mask;

    // pick the current result row
    assign row_raw = mxu_rows[row_sel];

    // drop the bytes below start_x
    assign row_shifted = row_raw >> win_shift;

    // ones below win_len, a full row gives an all-ones mask
    assign win_mask = ~({ROW_BITS{1'b1}} << win_len);

    assign wr_data = row_shifted & win_mask;

endmodule

//--- rtl/store_ctrl.sv
`timescale 1ns/100ps

module store_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_vld,
    input  lsu_pkg::lsu_op_t       instr_op,
    input  lsu_pkg::row_idx_t      start_x,
    input  lsu_pkg::row_idx_t      start_y,
    input  logic [7:0]             row_num,
    input  logic [2:0]             len,
    input  logic [11:0]            ld_st_addr,
    input  logic                   mxu_data_rdy,
    output logic                   instr_rdy,
    output lsu_pkg::row_idx_t      row_sel,
    output logic [6:0]             win_shift,
    output logic [7:0]             win_len,
    output logic [lsu_pkg::NUM_BANKS-1:0] wr_en,
    output lsu_pkg::buf_addr_t     wr_addr
);
    import lsu_pkg::*;

    store_state_t state_q;
    store_state_t state_nxt;

    // rows still to be written for the current instruction
    logic [7:0] remain_q;

    // payload captured at acceptance
    lsu_op_t    op_q;
    row_idx_t   row_q;
    buf_addr_t  addr_q;
    logic [6:0] shift_q;
    logic [7:0] len_q;

    logic accept;
    logic do_wr;
    logic last_wr;

    assign instr_rdy = (state_q == st_idle);
    assign accept    = instr_vld & instr_rdy;

    // one row per cycle while the matrix unit has data ready
    assign do_wr   = (state_q == st_store) & mxu_data_rdy;
    assign last_wr = do_wr & (remain_q == 8'd1);

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_nxt = st_store;
                end
            end
            st_store: begin
                if (last_wr) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= st_idle;
            remain_q <= '0;
        end else begin
            state_q <= state_nxt;
            if (accept) begin
                remain_q <= row_num;
            end else if (do_wr) begin
                remain_q <= remain_q - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= instr_op;
            row_q   <= start_y;
            // word address is the upper bits of the byte address
            addr_q  <= ld_st_addr[11:4];
            shift_q <= {start_x, 3'b000};
            len_q   <= window_bits(len);
        end else if (do_wr) begin
            row_q  <= row_q + 1'b1;
            addr_q <= addr_q + 1'b1;
        end
    end

    // write strobe goes to the bank named by the opcode
    always_comb begin
        wr_en = '0;
        if (do_wr) begin
            wr_en[bank_sel_t'(op_q)] = 1'b1;
        end
    end

    assign row_sel   = row_q;
    assign win_shift = shift_q;
    assign win_len   = len_q;
    assign wr_addr   = addr_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_lsu -f verilog.f -o tb_lsu --Mdir obj_dir; then
    echo "build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can report it
./obj_dir/tb_lsu +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

//--- verilog.f
rtl/lsu_pkg.sv
rtl/buffer_bank.sv
rtl/buffer_readout.sv
rtl/row_extract.sv
rtl/store_ctrl.sv
rtl/lsu_top.sv
bench/lsu_sva.sv
bench/tb_lsu.sv
